/* common/msu_defs.svh */
`ifndef MSU_DEFS_SVH
`define MSU_DEFS_SVH

// Data buffer geometry (16 KB)
`define MSU_BUF_AW    14
`define MSU_BUF_DEPTH (1 << `MSU_BUF_AW)

// Console register window
`define MSU_REG_COUNT 8
`define MSU_REG_AW    $clog2(`MSU_REG_COUNT)

// Identification string "S-MSU1", registers 2 to 7
`define MSU_ID0 8'h53
`define MSU_ID1 8'h2d
`define MSU_ID2 8'h4d
`define MSU_ID3 8'h53
`define MSU_ID4 8'h55
`define MSU_ID5 8'h31

`endif

/* common/msu_pkg.sv */
`default_nettype none

`include "msu_defs.svh"

package msu_pkg;

  ////////////////////////////////////////
  // Console side
  ////////////////////////////////////////

  // One synchronized console bus event
  typedef struct packed {
    logic                   rd_fall; // Read strobe asserted
    logic                   rd_rise; // Read strobe released
    logic                   wr_rise; // Write strobe released
    logic [`MSU_REG_AW-1:0] addr;
    logic [7:0]             data;
  } msu_bus_t;

  // Command registers toward the streaming engine
  typedef struct packed {
    logic [31:0] seek_addr;
    logic [15:0] track;
    logic [7:0]  volume;
    logic        volume_latch; // One cycle after a volume write
  } msu_cmd_t;

  ////////////////////////////////////////
  // Microcontroller side
  ////////////////////////////////////////

  // Status update from the supervisor
  typedef struct packed {
    logic       apply;
    logic [5:0] set_bits;
    logic [5:0] reset_bits;
  } msu_mcu_t;

  // Flag byte polled by the supervisor
  typedef struct packed {
    logic       ptr_msb;
    logic       audio_start;
    logic       data_start;
    logic       volume_start;
    logic [2:0] audio_ctrl;
    logic       ctrl_start;
  } msu_flags_t;

endpackage

`default_nettype wire

/* msu/msu_strobe_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msu_defs.svh"

module msu_strobe_sync
  import msu_pkg::*;
(
  input  logic                   clkin,
  input  logic                   reset,
  input  logic                   bus_rd_n,
  input  logic                   bus_wr_n,
  input  logic [`MSU_REG_AW-1:0] reg_addr,
  input  logic [7:0]             reg_data_in,
  input  logic                   mcu_apply,
  input  logic [5:0]             status_set_bits,
  input  logic [5:0]             status_reset_bits,
  input  logic                   ptr_load,
  output msu_bus_t               bus,
  output msu_mcu_t               mcu,
  output logic                   ptr_load_pulse
);

  // Strobe index 0 read, 1 write, 2 apply, 3 pointer load
  localparam int NSTB = 4;

  logic [NSTB-1:0]      stb_act;
  logic [NSTB-1:0][2:0] sreg;    // Two sync stages plus history
  logic [NSTB-1:0]      rise;
  logic [1:0]           fall;    // Only the bus strobes need release edges
  logic                 access_start;
  logic [`MSU_REG_AW-1:0] addr_q;
  logic [7:0]           data_q;

  // Everything in active-high form
  assign stb_act = {ptr_load, mcu_apply, ~bus_wr_n, ~bus_rd_n};

  always_ff @(posedge clkin) begin
    if (reset) begin
      sreg <= '0;
    end else begin
      for (int i = 0; i < NSTB; i++) begin
        sreg[i] <= {sreg[i][1:0], stb_act[i]};
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NSTB; i++) begin
      rise[i] = sreg[i][1] & ~sreg[i][2];
    end
    fall[0] = ~sreg[0][1] & sreg[0][2];
    fall[1] = ~sreg[1][1] & sreg[1][2];
  end

  // Address and data held from the start of the access for the release edge
  assign access_start = rise[0] | rise[1];

  always_ff @(posedge clkin) begin
    if (access_start) begin
      addr_q <= reg_addr;
      data_q <= reg_data_in;
    end
  end

  assign bus.rd_fall = rise[0];
  assign bus.rd_rise = fall[0];
  assign bus.wr_rise = fall[1];
  assign bus.addr    = access_start ? reg_addr : addr_q;
  assign bus.data    = access_start ? reg_data_in : data_q;

  // Masks are steady while the apply level is high
  assign mcu.apply      = rise[2];
  assign mcu.set_bits   = status_set_bits;
  assign mcu.reset_bits = status_reset_bits;

  assign ptr_load_pulse = rise[3];

endmodule

`default_nettype wire

/* msu/msu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msu_defs.svh"

module msu_ctrl
  import msu_pkg::*;
(
  input  logic       clkin,
  input  logic       reset,
  input  logic       enable,
  input  msu_bus_t   bus,
  input  msu_mcu_t   mcu,
  input  logic [7:0] buf_data,
  input  logic       ptr_msb,
  output logic [7:0] reg_data_out,
  output logic       ptr_advance,
  output msu_cmd_t   cmd,
  output msu_flags_t flags
);

  logic        rd_en;
  logic        wr_en;
  logic        inc_arm;
  logic [7:0]  status_byte;

  logic [31:0] seek_addr;
  logic [15:0] track;
  logic [7:0]  volume;
  logic        volume_start;

  logic        audio_busy;
  logic        data_busy;
  logic        audio_error;
  logic [1:0]  audio_status;
  logic [2:0]  audio_ctrl;
  logic        ctrl_start;
  logic        audio_start;
  logic        data_start;

  assign rd_en = bus.rd_fall & enable;
  assign wr_en = bus.wr_rise & enable;

  // Low three bits read back as a fixed revision code
  assign status_byte = {data_busy, audio_busy, audio_status, audio_error, 3'b010};

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset) begin
      reg_data_out <= '0;
    end else if (rd_en) begin
      case (bus.addr)
        3'd0: reg_data_out <= status_byte;
        3'd1: reg_data_out <= buf_data;
        3'd2: reg_data_out <= `MSU_ID0;
        3'd3: reg_data_out <= `MSU_ID1;
        3'd4: reg_data_out <= `MSU_ID2;
        3'd5: reg_data_out <= `MSU_ID3;
        3'd6: reg_data_out <= `MSU_ID4;
        default: reg_data_out <= `MSU_ID5;
      endcase
    end
  end

  // Only a data port read moves the pointer, once the strobe is released
  always_ff @(posedge clkin) begin
    if (reset) begin
      inc_arm <= 1'b0;
    end else if (rd_en && bus.addr == 3'd1) begin
      inc_arm <= 1'b1;
    end else if (bus.rd_rise) begin
      inc_arm <= 1'b0;
    end
  end

  assign ptr_advance = bus.rd_rise & inc_arm;

  ////////////////////////////////////////
  // Write side and status flags
  ////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset) begin
      volume_start <= 1'b0;
    end else begin
      volume_start <= wr_en && bus.addr == 3'd6; // Single-cycle latch pulse
    end
  end

  always_ff @(posedge clkin) begin
    if (reset) begin
      seek_addr    <= '0;
      track        <= '0;
      volume       <= '0;
      audio_busy   <= 1'b1;
      data_busy    <= 1'b1;
      audio_error  <= 1'b0;
      audio_status <= '0;
      audio_ctrl   <= '0;
      ctrl_start   <= 1'b0;
      audio_start  <= 1'b0;
      data_start   <= 1'b0;
    end else if (wr_en) begin
      case (bus.addr)
        3'd0: seek_addr[7:0]   <= bus.data;
        3'd1: seek_addr[15:8]  <= bus.data;
        3'd2: seek_addr[23:16] <= bus.data;
        3'd3: begin
          seek_addr[31:24] <= bus.data; // Top byte kicks off the seek
          data_start       <= 1'b1;
          data_busy        <= 1'b1;
        end
        3'd4: track[7:0] <= bus.data;
        3'd5: begin
          track[15:8] <= bus.data;
          audio_start <= 1'b1;
          audio_busy  <= 1'b1;
        end
        3'd6: volume <= bus.data;
        default: begin
          if (!audio_busy) begin // Control locked while a track loads
            audio_ctrl <= bus.data[2:0];
            ctrl_start <= 1'b1;
          end
        end
      endcase
    end else if (mcu.apply) begin
      // Set first, then reset wins
      audio_busy   <= (audio_busy | mcu.set_bits[5]) & ~mcu.reset_bits[5];
      data_busy    <= (data_busy | mcu.set_bits[4]) & ~mcu.reset_bits[4];
      audio_error  <= (audio_error | mcu.set_bits[3]) & ~mcu.reset_bits[3];
      audio_status <= (audio_status | mcu.set_bits[2:1]) & ~mcu.reset_bits[2:1];
      ctrl_start   <= (ctrl_start | mcu.set_bits[0]) & ~mcu.reset_bits[0];
      if (mcu.reset_bits[5]) begin
        audio_start <= 1'b0;
      end
      if (mcu.reset_bits[4]) begin
        data_start <= 1'b0;
      end
    end
  end

  assign cmd.seek_addr    = seek_addr;
  assign cmd.track        = track;
  assign cmd.volume       = volume;
  assign cmd.volume_latch = volume_start;

  assign flags.ptr_msb      = ptr_msb;
  assign flags.audio_start  = audio_start;
  assign flags.data_start   = data_start;
  assign flags.volume_start = volume_start;
  assign flags.audio_ctrl   = audio_ctrl;
  assign flags.ctrl_start   = ctrl_start;

endmodule

`default_nettype wire

/* msu/msu_read_ptr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msu_defs.svh"

module msu_read_ptr (
  input  logic                  clkin,
  input  logic                  reset,
  input  logic                  load_pulse,
  input  logic [`MSU_BUF_AW-1:0] load_value,
  input  logic                  advance,
  output logic [`MSU_BUF_AW-1:0] ptr
);

  ////////////////////////////////////////
  // Buffer read pointer
  ////////////////////////////////////////

  // The supervisor reload beats a console read
  always_ff @(posedge clkin) begin
    if (reset) begin
      ptr <= '0;
    end else if (load_pulse) begin
      ptr <= load_value;
    end else if (advance) begin
      ptr <= ptr + 1'b1; // Rolls over at the buffer end
    end
  end

endmodule

`default_nettype wire

/* msu/msu_databuf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msu_defs.svh"

module msu_databuf (
  input  logic                  clkin,
  input  logic                  we,
  input  logic [`MSU_BUF_AW-1:0] wr_addr,
  input  logic [7:0]            wr_data,
  input  logic [`MSU_BUF_AW-1:0] rd_addr,
  output logic [7:0]            rd_data
);

  // Simple dual-port block RAM
  logic [7:0] mem [`MSU_BUF_DEPTH];

  always_ff @(posedge clkin) begin
    if (we) begin
      mem[wr_addr] <= wr_data; // Supervisor fill port
    end
  end

  // One cycle read latency
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* rtl/msu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msu_defs.svh"

module msu_top
  import msu_pkg::*;
(
  input  logic                   clkin,
  input  logic                   reset,
  // Console bus
  input  logic                   enable,
  input  logic                   bus_rd_n,
  input  logic                   bus_wr_n,
  input  logic [`MSU_REG_AW-1:0] reg_addr,
  input  logic [7:0]             reg_data_in,
  output logic [7:0]             reg_data_out,
  // Buffer fill port
  input  logic [`MSU_BUF_AW-1:0]  pgm_address,
  input  logic [7:0]             pgm_data,
  input  logic                   pgm_we,
  // Supervisor control
  input  logic                   mcu_apply,
  input  logic [5:0]             status_set_bits,
  input  logic [5:0]             status_reset_bits,
  input  logic                   ptr_load,
  input  logic [`MSU_BUF_AW-1:0]  ptr_load_value,
  // Engine side
  output msu_cmd_t               cmd,
  output msu_flags_t             flags
);

  msu_bus_t               bus;
  msu_mcu_t               mcu;
  logic                   ptr_load_pulse;
  logic                   ptr_advance;
  logic [`MSU_BUF_AW-1:0] ptr;
  logic [7:0]             buf_data;

  ////////////////////////////////////////
  // Strobe synchronizers
  ////////////////////////////////////////

  msu_strobe_sync u_sync (
    .clkin             (clkin),
    .reset             (reset),
    .bus_rd_n          (bus_rd_n),
    .bus_wr_n          (bus_wr_n),
    .reg_addr          (reg_addr),
    .reg_data_in       (reg_data_in),
    .mcu_apply         (mcu_apply),
    .status_set_bits   (status_set_bits),
    .status_reset_bits (status_reset_bits),
    .ptr_load          (ptr_load),
    .bus               (bus),
    .mcu               (mcu),
    .ptr_load_pulse    (ptr_load_pulse)
  );

  ////////////////////////////////////////
  // Register file and flags
  ////////////////////////////////////////

  msu_ctrl u_ctrl (
    .clkin        (clkin),
    .reset        (reset),
    .enable       (enable),
    .bus          (bus),
    .mcu          (mcu),
    .buf_data     (buf_data),
    .ptr_msb      (ptr[`MSU_BUF_AW-1]),
    .reg_data_out (reg_data_out),
    .ptr_advance  (ptr_advance),
    .cmd          (cmd),
    .flags        (flags)
  );

  ////////////////////////////////////////
  // Data buffer path
  ////////////////////////////////////////

  msu_read_ptr u_ptr (
    .clkin      (clkin),
    .reset      (reset),
    .load_pulse (ptr_load_pulse),
    .load_value (ptr_load_value),
    .advance    (ptr_advance),
    .ptr        (ptr)
  );

  msu_databuf u_buf (
    .clkin   (clkin),
    .we      (pgm_we),
    .wr_addr (pgm_address),
    .wr_data (pgm_data),
    .rd_addr (ptr),
    .rd_data (buf_data)
  );

endmodule

`default_nettype wire

/* sim/msu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module msu_sva
  import msu_pkg::*;
(
  input logic       clkin,
  input logic       reset,
  input logic       enable,
  input msu_bus_t   bus,
  input msu_mcu_t   mcu,
  input logic       ptr_advance,
  input logic       audio_busy,
  input msu_cmd_t   cmd,
  input msu_flags_t flags
);

  logic       wr_en;
  logic [5:0] pulses;

  assign wr_en  = enable & bus.wr_rise;
  assign pulses = {bus.rd_fall, bus.rd_rise, bus.wr_rise, mcu.apply,
                   cmd.volume_latch, ptr_advance};

  ////////////////////////////////////////
  // Pulse and flag rules
  ////////////////////////////////////////

  // No pulse is high in two cycles in a row
  pulse_width: assert property (@(posedge clkin) disable iff (reset)
    (pulses & $past(pulses)) == '0)
    else $error("strobe pulse held for more than one cycle");

  latch_source: assert property (@(posedge clkin) disable iff (reset)
    cmd.volume_latch |-> $past(wr_en && bus.addr == 3'd6))
    else $error("volume latch without a register 6 write");

  ctrl_locked: assert property (@(posedge clkin) disable iff (reset)
    (wr_en && bus.addr == 3'd7 && audio_busy) |=>
      ($stable(flags.audio_ctrl) && $stable(flags.ctrl_start)))
    else $error("control field changed while audio busy");

endmodule

`default_nettype wire

/* sim/msu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msu_defs.svh"

module msu_tb
  import msu_pkg::*;
();

  localparam int BUF_BYTES    = 32;
  localparam int ACCESS_CYC   = 11; // One console access, update or pointer load
  localparam int ACCESS_COUNT = 7 + 9 + 11 + (BUF_BYTES + 3) + 6;
  localparam int MAX_CYCLES   = 2 * (ACCESS_CYC * ACCESS_COUNT + BUF_BYTES) + 10;
  localparam logic [`MSU_BUF_AW-1:0] BUF_BASE = 14'h3ff0; // Fill crosses the wrap

  logic                   clkin = 1'b0;
  logic                   reset;
  logic                   enable;
  logic                   bus_rd_n;
  logic                   bus_wr_n;
  logic [`MSU_REG_AW-1:0] reg_addr;
  logic [7:0]             reg_data_in;
  logic [7:0]             reg_data_out;
  logic [`MSU_BUF_AW-1:0] pgm_address;
  logic [7:0]             pgm_data;
  logic                   pgm_we;
  logic                   mcu_apply;
  logic [5:0]             status_set_bits;
  logic [5:0]             status_reset_bits;
  logic                   ptr_load_lvl;
  logic [`MSU_BUF_AW-1:0] ptr_load_value;
  msu_cmd_t               cmd;
  msu_flags_t             flags;

  int          err_count    = 0;
  int          check_count  = 0;
  int          cycle_count  = 0;
  int          latch_count  = 0;
  int          vstart_count = 0;
  logic [31:0] lfsr_state   = 32'hb9ba;
  logic [7:0]  exp_buf [BUF_BYTES];
  string       id_str       = "S-MSU1";

  msu_top dut0 (
    .clkin             (clkin),
    .reset             (reset),
    .enable            (enable),
    .bus_rd_n          (bus_rd_n),
    .bus_wr_n          (bus_wr_n),
    .reg_addr          (reg_addr),
    .reg_data_in       (reg_data_in),
    .reg_data_out      (reg_data_out),
    .pgm_address       (pgm_address),
    .pgm_data          (pgm_data),
    .pgm_we            (pgm_we),
    .mcu_apply         (mcu_apply),
    .status_set_bits   (status_set_bits),
    .status_reset_bits (status_reset_bits),
    .ptr_load          (ptr_load_lvl),
    .ptr_load_value    (ptr_load_value),
    .cmd               (cmd),
    .flags             (flags)
  );

  bind msu_ctrl msu_sva sva0 (
    .clkin       (clkin),
    .reset       (reset),
    .enable      (enable),
    .bus         (bus),
    .mcu         (mcu),
    .ptr_advance (ptr_advance),
    .audio_busy  (audio_busy),
    .cmd         (cmd),
    .flags       (flags)
  );

  always #10 clkin = ~clkin;

  // Volume latch and volume start pulses seen so far
  always @(posedge clkin) begin
    if (!reset && cmd.volume_latch) begin
      latch_count <= latch_count + 1;
    end
    if (!reset && flags.volume_start) begin
      vstart_count <= vstart_count + 1;
    end
  end

  always @(posedge clkin) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clkin);
    #2; // Inputs change just after the edge
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s done with %0d errors", name, err_count - errs_before);
  endtask

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      b[i]       = lfsr_state[0];
      lfsr_state = galois_step(lfsr_state);
    end
  endtask

  // Status register layout with revision code 010 in the low bits
  function automatic logic [7:0] status_expect(input logic data_busy, input logic audio_busy,
                                               input logic [1:0] st, input logic err);
    return {data_busy, audio_busy, st, err, 3'b010};
  endfunction

  ////////////////////////////////////////
  // Bus driver tasks
  ////////////////////////////////////////

  task automatic console_read(input logic [2:0] addr, output logic [7:0] data);
    reg_addr = addr;
    bus_rd_n = 1'b0;
    wait_cycles(5); // Latch lands 3 edges after the fall
    data     = reg_data_out;
    bus_rd_n = 1'b1;
    wait_cycles(5);
  endtask

  task automatic console_write(input logic [2:0] addr, input logic [7:0] data);
    reg_addr    = addr;
    reg_data_in = data;
    bus_wr_n    = 1'b0;
    wait_cycles(4);
    bus_wr_n    = 1'b1;
    wait_cycles(5);
  endtask

  task automatic mcu_update(input logic [5:0] set_bits, input logic [5:0] reset_bits);
    status_set_bits   = set_bits;
    status_reset_bits = reset_bits;
    mcu_apply         = 1'b1;
    wait_cycles(4);
    mcu_apply         = 1'b0;
    wait_cycles(2);
    status_set_bits   = '0;
    status_reset_bits = '0;
    wait_cycles(2);
  endtask

  task automatic pgm_write(input logic [`MSU_BUF_AW-1:0] addr, input logic [7:0] data);
    pgm_address = addr;
    pgm_data    = data;
    pgm_we      = 1'b1;
    wait_cycles(1);
    pgm_we      = 1'b0;
  endtask

  task automatic ptr_load(input logic [`MSU_BUF_AW-1:0] value);
    ptr_load_value = value;
    ptr_load_lvl   = 1'b1;
    wait_cycles(4);
    ptr_load_lvl   = 1'b0;
    wait_cycles(3);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic ident_bytes();
    logic [7:0] d;
    int         e0;
    e0 = err_count;
    console_read(3'd0, d);
    check_value("status after reset", 32'(d), 32'(status_expect(1'b1, 1'b1, 2'b00, 1'b0)));
    for (int i = 0; i < 6; i++) begin
      console_read(3'(i + 2), d);
      check_value("id byte", 32'(d), 32'(id_str[i]));
    end
    report_test("ident", e0);
  endtask

  task automatic seek_flow();
    logic [7:0] d;
    int         e0;
    e0 = err_count;
    mcu_update(6'b000000, 6'b010000); // Drop data busy first
    console_read(3'd0, d);
    check_value("status idle", 32'(d), 32'(status_expect(1'b0, 1'b1, 2'b00, 1'b0)));
    console_write(3'd0, 8'h78);
    console_write(3'd1, 8'h56);
    console_write(3'd2, 8'h34);
    console_write(3'd3, 8'h12);
    check_value("seek address", cmd.seek_addr, 32'h12345678);
    check_value("data start", 32'(flags.data_start), 32'd1);
    console_read(3'd0, d);
    check_value("status seeking", 32'(d), 32'(status_expect(1'b1, 1'b1, 2'b00, 1'b0)));
    mcu_update(6'b000000, 6'b010000);
    check_value("data start cleared", 32'(flags.data_start), 32'd0);
    console_read(3'd0, d);
    check_value("status seek done", 32'(d), 32'(status_expect(1'b0, 1'b1, 2'b00, 1'b0)));
    report_test("seek", e0);
  endtask

  task automatic track_volume_ctrl();
    logic [7:0] d;
    int         e0;
    int         l0;
    int         v0;
    e0 = err_count;
    console_write(3'd4, 8'hcd);
    console_write(3'd5, 8'hab);
    check_value("track", 32'(cmd.track), 32'h0000abcd);
    check_value("audio start", 32'(flags.audio_start), 32'd1);
    l0 = latch_count;
    v0 = vstart_count;
    console_write(3'd6, 8'h5a);
    check_value("volume", 32'(cmd.volume), 32'h5a);
    check_value("latch pulses", 32'(latch_count - l0), 32'd1);
    check_value("volume start pulses", 32'(vstart_count - v0), 32'd1);
    console_write(3'd7, 8'h05); // Audio still busy
    check_value("control while busy", 32'(flags.audio_ctrl), 32'd0);
    check_value("control start while busy", 32'(flags.ctrl_start), 32'd0);
    mcu_update(6'b000000, 6'b100000);
    check_value("audio start cleared", 32'(flags.audio_start), 32'd0);
    console_read(3'd0, d);
    check_value("status audio idle", 32'(d), 32'(status_expect(1'b0, 1'b0, 2'b00, 1'b0)));
    console_write(3'd7, 8'h05);
    check_value("control", 32'(flags.audio_ctrl), 32'd5);
    check_value("control start", 32'(flags.ctrl_start), 32'd1);
    mcu_update(6'b000000, 6'b000001);
    check_value("control start cleared", 32'(flags.ctrl_start), 32'd0);
    report_test("track_volume", e0);
  endtask

  task automatic buffer_stream();
    logic [7:0]             b;
    logic [7:0]             d;
    logic [`MSU_BUF_AW-1:0] a;
    int                     e0;
    e0 = err_count;
    a  = BUF_BASE;
    for (int i = 0; i < BUF_BYTES; i++) begin
      random_byte(b);
      exp_buf[i] = b;
      pgm_write(a, b);
      a = a + 1'b1;
    end
    ptr_load(BUF_BASE);
    check_value("pointer top bit at base", 32'(flags.ptr_msb), 32'd1);
    for (int i = 0; i < BUF_BYTES; i++) begin
      console_read(3'd1, d);
      check_value("buffer byte", 32'(d), 32'(exp_buf[i]));
      if (i == 12) begin
        console_read(3'd0, d); // Neither read may move the pointer
        console_read(3'd3, d);
      end
    end
    check_value("pointer top bit after wrap", 32'(flags.ptr_msb), 32'd0);
    report_test("buffer", e0);
  endtask

  task automatic status_and_enable();
    logic [7:0] d;
    int         e0;
    int         l0;
    e0 = err_count;
    mcu_update(6'b001110, 6'b000000);
    console_read(3'd0, d);
    check_value("status error", 32'(d), 32'(status_expect(1'b0, 1'b0, 2'b11, 1'b1)));
    enable = 1'b0;
    l0     = latch_count;
    console_write(3'd6, 8'h11);
    console_write(3'd0, 8'hff);
    check_value("volume disabled", 32'(cmd.volume), 32'h5a);
    check_value("seek disabled", cmd.seek_addr, 32'h12345678);
    check_value("latch disabled", 32'(latch_count - l0), 32'd0);
    console_read(3'd2, d);
    check_value("read disabled", 32'(d), 32'(status_expect(1'b0, 1'b0, 2'b11, 1'b1)));
    enable = 1'b1;
    report_test("status_enable", e0);
  endtask

  initial begin
    reset             = 1'b1;
    enable            = 1'b1;
    bus_rd_n          = 1'b1;
    bus_wr_n          = 1'b1;
    reg_addr          = '0;
    reg_data_in       = '0;
    pgm_address       = '0;
    pgm_data          = '0;
    pgm_we            = 1'b0;
    mcu_apply         = 1'b0;
    status_set_bits   = '0;
    status_reset_bits = '0;
    ptr_load_lvl      = 1'b0;
    ptr_load_value    = '0;
    repeat (3) @(posedge clkin);
    #2;
    reset = 1'b0;
    wait_cycles(2);
    ident_bytes();
    seek_flow();
    track_volume_ctrl();
    buffer_stream();
    status_and_enable();
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/msu_pkg.sv
msu/msu_strobe_sync.sv
msu/msu_ctrl.sv
msu/msu_read_ptr.sv
msu/msu_databuf.sv
rtl/msu_top.sv
sim/msu_sva.sv
sim/msu_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the MSU register block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module msu_tb \
  -o msu_sim

obj_dir/msu_sim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation failed"
  exit 1
fi
